/* dv/ptw_trace.txt */
# M <pte address hex> <pte data hex> <E = bus error, - = okay>
# T <iova> <pscid> <store> <iosatp ppn> <U|F> <ppn> <2m> <1g> <g> <cause decimal>
# Root table 0x100, level-2 table 0x200, level-3 table 0x300
M 100008 0000000000080001 -
M 100010 0000000000080021 -
M 100020 00000000100000CF -
M 100028 00000000100004CF -
M 100030 0000000000080041 -
M 100038 0000000000080081 -
M 100040 0000000000080001 E
M 200010 00000000000C0001 -
M 200038 00000000049000CF -
M 200040 00000000049004CF -
M 200048 00000000000C0011 -
M 300018 00000000048D14CF -
M 300020 00000000048D14CE -
M 300028 00000000048D14C5 -
M 300030 00000000048D1447 -
M 300038 00000000048D148F -
M 300040 00000000000C0001 -
M 300048 00400000048D14CF -
M 300050 00000000048D14CF E
# Second root table 0x400 with a global 1G leaf
M 400008 00000000200000EF -
# 4K leaf, load then store
T 40403000 00abc 0 100 U 12345 0 0 0 0
T 40403000 00abd 1 100 U 12345 0 0 0 0
# Superpages, aligned and misaligned
T 100A06000 00011 0 100 U 40000 0 1 0 0
T 140000000 00012 0 100 F 0 0 0 0 13
T 40E00000 00013 0 100 U 12400 1 0 0 0
T 41000000 00014 1 100 F 0 0 0 0 15
# V clear and write-only leaves
T 40404000 00021 0 100 F 0 0 0 0 13
T 40404000 00022 1 100 F 0 0 0 0 15
T 40405000 00023 1 100 F 0 0 0 0 15
T 40405000 00024 0 100 F 0 0 0 0 13
# D clear faults only on store, A clear always faults
T 40406000 00025 1 100 F 0 0 0 0 15
T 40406000 00026 0 100 U 12345 0 0 0 0
T 40407000 00027 0 100 F 0 0 0 0 13
# Pointer with A, D, U, pointer at level 3, reserved bits
T 180000000 00031 0 100 F 0 0 0 0 13
T 1C0000000 00032 1 100 F 0 0 0 0 15
T 41200000 00033 0 100 F 0 0 0 0 13
T 40408000 00034 0 100 F 0 0 0 0 13
T 40409000 00035 0 100 F 0 0 0 0 13
# Bus errors at level 3 and at the root
T 4040A000 00041 0 100 F 0 0 0 0 274
T 200000000 00042 1 100 F 0 0 0 0 274
# Global root pointer, unmapped root entry, other root
T 80403000 00051 0 100 U 12345 0 0 1 0
T C0000000 00052 0 100 F 0 0 0 0 13
T 40000000 00053 1 400 U 80000 0 1 1 0

/* verilog.f */
+incdir+src
src/ptw_types_pkg.sv
src/ptw_mem_pkg.sv
src/ptw_pte_check.sv
src/ptw_walk_fsm.sv
src/ptw_context_regs.sv
src/iommu_ptw_top.sv
dv/tb_iommu_ptw.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the page table walker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_iommu_ptw -f verilog.f

sim_out=$(./obj_dir/Vtb_iommu_ptw 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'TB PASSED'; then
    exit 0
fi
exit 1

/* dv/tb_iommu_ptw.sv */
/*
 * Testbench for the Sv39 IOMMU page table walker
 * Replays walks from a trace against a sparse page-table memory with random stalls
 */
`include "ptw_params.svh"

module tb_iommu_ptw
    import ptw_types_pkg::*;
    import ptw_mem_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // One translation request with its expected outcome
    typedef struct packed {
        logic [`PTW_VLEN-1:0]       iova;
        logic [`PTW_PSCID_W-1:0]    pscid;
        logic                       is_store;
        logic [`PTW_PPNW-1:0]       satp_ppn;
        logic                       is_err;
        logic [`PTW_PPNW-1:0]       ppn;
        logic                       is_2m;
        logic                       is_1g;
        logic                       g;
        logic [`PTW_CAUSE_W-1:0]    cause;
    } trace_entry_t;

    // DUT inputs
    logic                       clk_i = 1'b0;
    logic                       rst_ni = 1'b0;
    logic                       walk_req_i = 1'b0;
    walk_ctx_t                  walk_ctx_i = '0;
    logic [`PTW_PPNW-1:0]       iosatp_ppn_i = '0;
    logic                       mem_ar_ready_i = 1'b0;
    logic                       mem_r_valid_i = 1'b0;
    mem_rd_rsp_t                mem_r_i = '0;

    // DUT outputs
    logic                       walk_ack_o;
    logic                       busy_o;
    logic                       update_valid_o;
    iotlb_update_t              update_o;
    logic                       error_valid_o;
    logic [`PTW_CAUSE_W-1:0]    cause_o;
    logic                       mem_ar_valid_o;
    mem_rd_req_t                mem_ar_o;
    logic                       mem_r_ready_o;

    // Sparse page-table image, plus addresses that answer with a bus error
    logic [63:0]                mem_img [logic [`PTW_PLEN-1:0]];
    bit                         mem_bad [logic [`PTW_PLEN-1:0]];
    trace_entry_t               tests [$];

    // Memory model state
    logic [`PTW_PLEN-1:0]       rd_addr;
    bit                         rd_pend = 1'b0;
    int                         ar_cnt = -1;
    int                         r_cnt = 0;
    mem_rd_rsp_t                rsp;
    integer                     seed = 32'heb44;

    int                         errors = 0;
    int                         n_checks = 0;
    int                         cycles = 0;
    int                         cycle_limit = 100000;

    iommu_ptw_top UUT (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .walk_req_i     (walk_req_i),
        .walk_ctx_i     (walk_ctx_i),
        .iosatp_ppn_i   (iosatp_ppn_i),
        .walk_ack_o     (walk_ack_o),
        .busy_o         (busy_o),
        .update_valid_o (update_valid_o),
        .update_o       (update_o),
        .error_valid_o  (error_valid_o),
        .cause_o        (cause_o),
        .mem_ar_valid_o (mem_ar_valid_o),
        .mem_ar_o       (mem_ar_o),
        .mem_ar_ready_i (mem_ar_ready_i),
        .mem_r_valid_i  (mem_r_valid_i),
        .mem_r_i        (mem_r_i),
        .mem_r_ready_o  (mem_r_ready_o)
    );

    initial begin
        forever #20 clk_i = ~clk_i;
    end

    // Stall of 0 to 3 cycles
    function automatic int pick_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
        end
    endtask

    // Memory model serving one read at a time with random stalls on both phases
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            mem_ar_ready_i <= 1'b0;
            mem_r_valid_i  <= 1'b0;
            rd_pend = 1'b0;
            ar_cnt  = -1;
        end else begin
            // Data phase
            if (mem_r_valid_i && mem_r_ready_o) begin
                mem_r_valid_i <= 1'b0;
                rd_pend = 1'b0;
            end else if (rd_pend && !mem_r_valid_i) begin
                if (r_cnt == 0) begin
                    rsp.data = mem_img.exists(rd_addr) ? mem_img[rd_addr] : 64'h0;
                    rsp.resp = mem_bad.exists(rd_addr) ? 2'b10 : MEM_RESP_OKAY;
                    mem_r_i       <= rsp;
                    mem_r_valid_i <= 1'b1;
                end else begin
                    r_cnt--;
                end
            end
            // Address phase
            if (mem_ar_valid_o && mem_ar_ready_i) begin
                rd_addr = mem_ar_o.addr;
                rd_pend = 1'b1;
                r_cnt   = pick_delay();
                ar_cnt  = -1;
                mem_ar_ready_i <= 1'b0;
            end else if (mem_ar_valid_o && !rd_pend) begin
                if (ar_cnt < 0) begin
                    ar_cnt = pick_delay();
                end
                if (ar_cnt == 0) begin
                    mem_ar_ready_i <= 1'b1;
                end else begin
                    ar_cnt--;
                end
            end
        end
    end

    // Watchdog
    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, a walk never completed", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // M lines load memory and T lines queue walks
    task automatic read_trace(output bit ok);
        int             fd;
        int             n;
        int             cause;
        string          line;
        byte            tag;
        byte            flag;
        byte            kind;
        logic [63:0]    f_a, f_b, f_c, f_d, f_e, f_f, f_g, f_h;
        trace_entry_t   e;
        ok = 1'b0;
        fd = $fopen("dv/ptw_trace.txt", "r");
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line[0] == "M") begin
                n = $sscanf(line, "%c %h %h %c", tag, f_a, f_b, flag);
                if (n != 4) begin
                    $display("Malformed memory line in trace: %s", line);
                    errors++;
                end
                mem_img[f_a[`PTW_PLEN-1:0]] = f_b;
                if (flag == "E") begin
                    mem_bad[f_a[`PTW_PLEN-1:0]] = 1'b1;
                end
            end else if (line[0] == "T") begin
                n = $sscanf(line, "%c %h %h %h %h %c %h %h %h %h %d", tag, f_a, f_b,
                            f_c, f_d, kind, f_e, f_f, f_g, f_h, cause);
                if (n != 11) begin
                    $display("Malformed walk line in trace: %s", line);
                    errors++;
                end
                e.iova     = f_a[`PTW_VLEN-1:0];
                e.pscid    = f_b[`PTW_PSCID_W-1:0];
                e.is_store = f_c[0];
                e.satp_ppn = f_d[`PTW_PPNW-1:0];
                e.is_err   = (kind == "F");
                e.ppn      = f_e[`PTW_PPNW-1:0];
                e.is_2m    = f_f[0];
                e.is_1g    = f_g[0];
                e.g        = f_h[0];
                e.cause    = cause[`PTW_CAUSE_W-1:0];
                tests.push_back(e);
            end
        end
        $fclose(fd);
        ok = (tests.size() > 0);
    endtask

    task automatic check_reset_state();
        check_val("walk_ack_o", 64'(walk_ack_o), 64'd0);
        check_val("busy_o", 64'(busy_o), 64'd0);
        check_val("mem_ar_valid_o", 64'(mem_ar_valid_o), 64'd0);
        check_val("mem_r_ready_o", 64'(mem_r_ready_o), 64'd0);
        check_val("update_valid_o", 64'(update_valid_o), 64'd0);
        check_val("error_valid_o", 64'(error_valid_o), 64'd0);
    endtask

    task automatic check_results(input trace_entry_t t);
        if (!t.is_err) begin
            check_val("update_valid_o", 64'(update_valid_o), 64'd1);
            check_val("error_valid_o", 64'(error_valid_o), 64'd0);
            check_val("update_o.vpn", 64'(update_o.vpn), 64'(t.iova[`PTW_VLEN-1:12]));
            check_val("update_o.pscid", 64'(update_o.pscid), 64'(t.pscid));
            check_val("update_o.content.ppn", 64'(update_o.content.ppn), 64'(t.ppn));
            check_val("update_o.is_2m", 64'(update_o.is_2m), 64'(t.is_2m));
            check_val("update_o.is_1g", 64'(update_o.is_1g), 64'(t.is_1g));
            check_val("update_o.content.g", 64'(update_o.content.g), 64'(t.g));
        end else begin
            check_val("error_valid_o", 64'(error_valid_o), 64'd1);
            check_val("update_valid_o", 64'(update_valid_o), 64'd0);
            check_val("cause_o", 64'(cause_o), 64'(t.cause));
        end
    endtask

    // Four-phase request with the result checked once ack is up
    task automatic run_walk(input trace_entry_t t);
        walk_ctx_t  ctx;
        ctx.iova     = t.iova;
        ctx.pscid    = t.pscid;
        ctx.is_store = t.is_store;
        @(posedge clk_i);
        walk_ctx_i   <= ctx;
        iosatp_ppn_i <= t.satp_ppn;
        walk_req_i   <= 1'b1;
        @(negedge clk_i);
        while (!walk_ack_o) begin
            @(negedge clk_i);
        end
        check_val("busy_o", 64'(busy_o), 64'd1);
        check_results(t);
        // Holding req must keep ack and the result steady
        repeat (2) begin
            @(negedge clk_i);
            check_val("walk_ack_o", 64'(walk_ack_o), 64'd1);
            check_results(t);
        end
        @(posedge clk_i);
        walk_req_i <= 1'b0;
        @(negedge clk_i);
        while (walk_ack_o) begin
            @(negedge clk_i);
        end
    endtask

    initial begin
        bit trace_ok;
        read_trace(trace_ok);
        if (!trace_ok) begin
            $display("Could not read any walks from dv/ptw_trace.txt");
            $display("TB FAILED");
            $finish;
        end else begin
            cycle_limit = 60 * tests.size() + 20;
            repeat (5) @(posedge clk_i);
            rst_ni <= 1'b1;
            @(negedge clk_i);
            check_reset_state();
            foreach (tests[i]) begin
                run_walk(tests[i]);
            end
            $display("Walks: %0d  checks: %0d  errors: %0d", tests.size(), n_checks, errors);
            if (errors == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule

/* src/iommu_ptw_top.sv */
/*
 * Sv39 IOMMU page table walker
 * Walk sequencer, PTE checker and result registers
 */
`include "ptw_params.svh"

module iommu_ptw_top
    import ptw_types_pkg::*;
    import ptw_mem_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_ni,
    // Four-phase walk request
    input  logic                        walk_req_i,
    input  walk_ctx_t                   walk_ctx_i,
    input  logic [`PTW_PPNW-1:0]        iosatp_ppn_i,
    output logic                        walk_ack_o,
    output logic                        busy_o,
    // Walk result
    output logic                        update_valid_o,
    output iotlb_update_t               update_o,
    output logic                        error_valid_o,
    output logic [`PTW_CAUSE_W-1:0]     cause_o,
    // Memory read port
    output logic                        mem_ar_valid_o,
    output mem_rd_req_t                 mem_ar_o,
    input  logic                        mem_ar_ready_i,
    input  logic                        mem_r_valid_i,
    input  mem_rd_rsp_t                 mem_r_i,
    output logic                        mem_r_ready_o
);

    walk_ctx_t      ctx;
    pte_verdict_t   verdict;
    walk_lvl_e      lvl;
    pte_t           pte;
    logic           capture;
    logic           pte_accept;
    logic           done_ok;
    logic           done_err;
    logic           err_is_data;

    ptw_walk_fsm u_walk_fsm (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .walk_req_i     (walk_req_i),
        .iosatp_ppn_i   (iosatp_ppn_i),
        .ctx_i          (ctx),
        .verdict_i      (verdict),
        .mem_ar_ready_i (mem_ar_ready_i),
        .mem_r_valid_i  (mem_r_valid_i),
        .mem_r_i        (mem_r_i),
        .walk_ack_o     (walk_ack_o),
        .busy_o         (busy_o),
        .capture_o      (capture),
        .mem_ar_valid_o (mem_ar_valid_o),
        .mem_ar_o       (mem_ar_o),
        .mem_r_ready_o  (mem_r_ready_o),
        .lvl_o          (lvl),
        .pte_o          (pte),
        .pte_accept_o   (pte_accept),
        .done_ok_o      (done_ok),
        .done_err_o     (done_err),
        .err_is_data_o  (err_is_data)
    );

    // Checks the PTE on the read data bus
    ptw_pte_check u_pte_check (
        .pte_i      (pte),
        .lvl_i      (lvl),
        .is_store_i (ctx.is_store),
        .verdict_o  (verdict)
    );

    ptw_context_regs u_context_regs (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .capture_i      (capture),
        .walk_ctx_i     (walk_ctx_i),
        .pte_accept_i   (pte_accept),
        .global_i       (verdict.is_global),
        .done_ok_i      (done_ok),
        .done_err_i     (done_err),
        .err_is_data_i  (err_is_data),
        .lvl_i          (lvl),
        .pte_i          (pte),
        .ctx_o          (ctx),
        .update_valid_o (update_valid_o),
        .update_o       (update_o),
        .error_valid_o  (error_valid_o),
        .cause_o        (cause_o)
    );

endmodule

/* src/ptw_context_regs.sv */
/*
 * Walk context and result registers
 * Latch the request, collect the global bit, and hold the IOTLB entry
 * or the cause code until the next walk starts
 */
`include "ptw_params.svh"

module ptw_context_regs
    import ptw_types_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        capture_i,
    input  walk_ctx_t                   walk_ctx_i,
    input  logic                        pte_accept_i,
    input  logic                        global_i,
    input  logic                        done_ok_i,
    input  logic                        done_err_i,
    input  logic                        err_is_data_i,
    input  walk_lvl_e                   lvl_i,
    input  pte_t                        pte_i,
    output walk_ctx_t                   ctx_o,
    output logic                        update_valid_o,
    output iotlb_update_t               update_o,
    output logic                        error_valid_o,
    output logic [`PTW_CAUSE_W-1:0]     cause_o
);

    walk_ctx_t                  ctx_q;
    logic                       global_q;
    iotlb_update_t              update_d;
    iotlb_update_t              update_q;
    logic [`PTW_CAUSE_W-1:0]    cause_d;
    logic [`PTW_CAUSE_W-1:0]    cause_q;

    // Entry for the leaf being accepted now
    always_comb begin
        update_d            = '0;
        update_d.vpn        = ctx_q.iova[`PTW_VLEN-1:12];
        update_d.pscid      = ctx_q.pscid;
        update_d.is_2m      = (lvl_i == LVL2);
        update_d.is_1g      = (lvl_i == LVL1);
        update_d.content    = pte_i;
        // G on any level above makes the whole mapping global
        update_d.content.g  = pte_i.g | global_q;
    end

    // Page fault cause follows the access type
    always_comb begin
        if (err_is_data_i) begin
            cause_d = `PTW_CAUSE_W'(`PTW_CAUSE_DATA_CORRUPT);
        end else if (ctx_q.is_store) begin
            cause_d = `PTW_CAUSE_W'(`PTW_CAUSE_STORE_PF);
        end else begin
            cause_d = `PTW_CAUSE_W'(`PTW_CAUSE_LOAD_PF);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            global_q       <= 1'b0;
            update_valid_o <= 1'b0;
            error_valid_o  <= 1'b0;
        end else if (capture_i) begin
            global_q       <= 1'b0;
            update_valid_o <= 1'b0;
            error_valid_o  <= 1'b0;
        end else begin
            if (pte_accept_i && global_i) begin
                global_q <= 1'b1;
            end
            if (done_ok_i) begin
                update_valid_o <= 1'b1;
            end
            if (done_err_i) begin
                error_valid_o <= 1'b1;
            end
        end
    end

    // Payload, qualified by the valid flags above
    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            ctx_q <= walk_ctx_i;
        end
        if (done_ok_i) begin
            update_q <= update_d;
        end
        if (done_err_i) begin
            cause_q <= cause_d;
        end
    end

    assign ctx_o    = ctx_q;
    assign update_o = update_q;
    assign cause_o  = cause_q;

    // FSM ends a walk with exactly one kind of result
    a_one_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(update_valid_o && error_valid_o));

endmodule

/* src/ptw_walk_fsm.sv */
/*
 * Walk sequencer
 * Runs the four-phase request, issues one PTE read per level and
 * decides from the checker verdict whether to descend, finish or fail
 */
`include "ptw_params.svh"

module ptw_walk_fsm
    import ptw_types_pkg::*;
    import ptw_mem_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    walk_req_i,
    input  logic [`PTW_PPNW-1:0]    iosatp_ppn_i,
    input  walk_ctx_t               ctx_i,
    input  pte_verdict_t            verdict_i,
    input  logic                    mem_ar_ready_i,
    input  logic                    mem_r_valid_i,
    input  mem_rd_rsp_t             mem_r_i,
    output logic                    walk_ack_o,
    output logic                    busy_o,
    output logic                    capture_o,
    output logic                    mem_ar_valid_o,
    output mem_rd_req_t             mem_ar_o,
    output logic                    mem_r_ready_o,
    output walk_lvl_e               lvl_o,
    output pte_t                    pte_o,
    output logic                    pte_accept_o,
    output logic                    done_ok_o,
    output logic                    done_err_o,
    output logic                    err_is_data_o
);

    // Byte offset bits of a PTE inside its table
    localparam int PTE_OFS_W = $clog2(`PTW_PTE_BYTES);

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,
        WAIT_DATA,
        DONE,
        RELEASE
    } state_e;

    state_e                 state_q, state_n;
    walk_lvl_e              lvl_q, lvl_n;
    logic [`PTW_PPNW-1:0]   base_ppn_q, base_ppn_n;
    logic [8:0]             vpn_slice;

    // VPN index of the table being read
    always_comb begin
        case (lvl_q)
            LVL1:    vpn_slice = ctx_i.iova[38:30];
            LVL2:    vpn_slice = ctx_i.iova[29:21];
            default: vpn_slice = ctx_i.iova[20:12];
        endcase
    end

    // PTE address held steady through ISSUE
    assign mem_ar_o.addr = {base_ppn_q, vpn_slice, {PTE_OFS_W{1'b0}}};

    // Response data seen as a PTE for the checker
    assign pte_o  = pte_t'(mem_r_i.data);
    assign lvl_o  = lvl_q;
    assign busy_o = (state_q != IDLE);

    always_comb begin
        state_n        = state_q;
        lvl_n          = lvl_q;
        base_ppn_n     = base_ppn_q;
        capture_o      = 1'b0;
        mem_ar_valid_o = 1'b0;
        mem_r_ready_o  = 1'b0;
        walk_ack_o     = 1'b0;
        pte_accept_o   = 1'b0;
        done_ok_o      = 1'b0;
        done_err_o     = 1'b0;
        err_is_data_o  = 1'b0;

        case (state_q)
            IDLE: begin
                // Start at the root table named by iosatp
                if (walk_req_i) begin
                    capture_o  = 1'b1;
                    lvl_n      = LVL1;
                    base_ppn_n = iosatp_ppn_i;
                    state_n    = ISSUE;
                end
            end

            ISSUE: begin
                mem_ar_valid_o = 1'b1;
                if (mem_ar_ready_i) begin
                    state_n = WAIT_DATA;
                end
            end

            WAIT_DATA: begin
                mem_r_ready_o = 1'b1;
                if (mem_r_valid_i) begin
                    // Bus error wins over anything the PTE says
                    if (mem_r_i.resp != MEM_RESP_OKAY) begin
                        done_err_o    = 1'b1;
                        err_is_data_o = 1'b1;
                        state_n       = DONE;
                    end else if (verdict_i.is_fault) begin
                        done_err_o = 1'b1;
                        state_n    = DONE;
                    end else begin
                        pte_accept_o = 1'b1;
                        if (verdict_i.is_leaf) begin
                            done_ok_o = 1'b1;
                            state_n   = DONE;
                        end else begin
                            // Descend one level on a pointer
                            base_ppn_n = verdict_i.next_ppn;
                            lvl_n      = (lvl_q == LVL1) ? LVL2 : LVL3;
                            state_n    = ISSUE;
                        end
                    end
                end
            end

            DONE: begin
                // Ack stays up as long as the requester holds req
                walk_ack_o = 1'b1;
                if (!walk_req_i) begin
                    state_n = RELEASE;
                end
            end

            RELEASE: begin
                state_n = IDLE;
            end

            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            lvl_q   <= LVL1;
        end else begin
            state_q <= state_n;
            lvl_q   <= lvl_n;
        end
    end

    // Table base of the level being read
    always_ff @(posedge clk_i) begin
        base_ppn_q <= base_ppn_n;
    end

    // Read address must not move before the memory takes it
    a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o && $stable(mem_ar_o));

    // Ack only answers a pending request
    a_ack_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(walk_ack_o) |-> walk_req_i);

endmodule

/* src/ptw_pte_check.sv */
/*
 * PTE checker
 * Classifies one Sv39 PTE at a given level as leaf, pointer or fault
 */
`include "ptw_params.svh"

module ptw_pte_check
    import ptw_types_pkg::*;
(
    input  pte_t            pte_i,
    input  walk_lvl_e       lvl_i,
    input  logic            is_store_i,
    output pte_verdict_t    verdict_o
);

    logic invalid;
    logic leaf;
    logic rsvd_fault;
    logic misaligned;
    logic leaf_fault;
    logic ptr_fault;

    // V clear, or write-only encoding
    assign invalid = !pte_i.v || (!pte_i.r && pte_i.w);

    // Any of R or X marks a leaf
    assign leaf = pte_i.r || pte_i.x;

    // Svnapot and Svpbmt are not supported, upper bits must be zero
    assign rsvd_fault = |pte_i.reserved;

    // Superpage PPN must be aligned to its size
    always_comb begin
        misaligned = 1'b0;
        case (lvl_i)
            LVL1:    misaligned = |pte_i.ppn[17:0];
            LVL2:    misaligned = |pte_i.ppn[8:0];
            default: misaligned = 1'b0;
        endcase
    end

    // Leaf needs A set, R set, and D set for stores
    assign leaf_fault = misaligned
                     || !pte_i.a
                     || !pte_i.r
                     || (is_store_i && !pte_i.d);

    // D, A, U are reserved on pointers
    // A pointer at the last level has nowhere to go
    assign ptr_fault = pte_i.a || pte_i.d || pte_i.u || (lvl_i == LVL3);

    always_comb begin
        verdict_o.is_leaf   = pte_i.v && leaf;
        verdict_o.is_fault  = invalid || rsvd_fault || (leaf ? leaf_fault : ptr_fault);
        // Base of the next table when this is a pointer
        verdict_o.next_ppn  = pte_i.ppn;
        verdict_o.is_global = pte_i.g;
    end

endmodule

/* src/ptw_mem_pkg.sv */
/*
 * Memory read port types for the walker
 * Read address and read data beats plus response status
 */
`include "ptw_params.svh"

package ptw_mem_pkg;

    // Response status of a read beat
    localparam logic [1:0] MEM_RESP_OKAY = 2'b00;

    // Read address, always one full PTE
    typedef struct packed {
        logic [`PTW_PLEN-1:0] addr;
    } mem_rd_req_t;

    // Read data beat, one PTE wide
    typedef struct packed {
        logic [8*`PTW_PTE_BYTES-1:0]    data;
        logic [1:0]                     resp;
    } mem_rd_rsp_t;

endpackage

/* src/ptw_types_pkg.sv */
/*
 * Translation types for the Sv39 walker
 * PTE layout, walk level, checker verdict, walk context and IOTLB update entry
 */
`include "ptw_params.svh"

package ptw_types_pkg;

    // Sv39 page table entry, bit 63 first
    typedef struct packed {
        logic [9:0]             reserved;
        logic [`PTW_PPNW-1:0]   ppn;
        logic [1:0]             rsw;
        logic                   d;
        logic                   a;
        logic                   g;
        logic                   u;
        logic                   x;
        logic                   w;
        logic                   r;
        logic                   v;
    } pte_t;

    // Level being walked, LVL1 is the root table
    typedef enum logic [$clog2(`PTW_LEVELS)-1:0] {
        LVL1,
        LVL2,
        LVL3
    } walk_lvl_e;

    // Result of checking one PTE
    typedef struct packed {
        logic                   is_leaf;
        logic                   is_fault;
        logic [`PTW_PPNW-1:0]   next_ppn;
        logic                   is_global;
    } pte_verdict_t;

    // Request context latched at the start of a walk
    typedef struct packed {
        logic [`PTW_VLEN-1:0]       iova;
        logic [`PTW_PSCID_W-1:0]    pscid;
        logic                       is_store;
    } walk_ctx_t;

    // Entry handed to the IOTLB after a good walk
    typedef struct packed {
        logic [`PTW_VLEN-13:0]      vpn;
        logic [`PTW_PSCID_W-1:0]    pscid;
        logic                       is_2m;
        logic                       is_1g;
        pte_t                       content;
    } iotlb_update_t;

endpackage

/* src/ptw_params.svh */
/*
 * Sv39 page table walker constants
 * Address and PPN widths, walk depth, PTE size and the IOMMU cause codes
 */
`ifndef PTW_PARAMS_SVH
`define PTW_PARAMS_SVH

// IOVA, physical address and PPN widths for Sv39
`define PTW_VLEN        39
`define PTW_PLEN        56
`define PTW_PPNW        44

// Three table levels, 8-byte PTEs
`define PTW_LEVELS      3
`define PTW_PTE_BYTES   8

// Process soft-context ID width
`define PTW_PSCID_W     20

// Cause codes reported with a failed walk
`define PTW_CAUSE_W             11
`define PTW_CAUSE_LOAD_PF       13
`define PTW_CAUSE_STORE_PF      15
`define PTW_CAUSE_DATA_CORRUPT  274

`endif
